/* verilog/nlp_coeffs.svh */
`ifndef NLP_COEFFS_SVH
`define NLP_COEFFS_SVH

// --------------------
// low-pass FIR
// --------------------

// symmetric 48-tap low-pass in Q16
// index 0 weights the oldest sample in the delay line
localparam acc_t fir_coeff [FIR_TAPS] = '{
	-71, -72, -61, -28,
	36, 131, 243, 337,
	367, 282, 53, -316,
	-767, -1193, -1446, -1371,
	-839, 211, 1749, 3639,
	5656, 7524, 8962, 9744,
	9744, 8962, 7524, 5656,
	3639, 1749, 211, -839,
	-1371, -1446, -1193, -767,
	-316, 53, 282, 367,
	337, 243, 131, 36,
	-28, -61, -72, -71
};

// --------------------
// analysis window
// --------------------

// hanning window over the 64 decimated samples, Q16
// 0.5 - 0.5*cos(2*pi*i/63)
localparam acc_t win_coeff [WIN_LEN] = '{
	0, 163, 650, 1456,
	2573, 3990, 5694, 7666,
	9888, 12337, 14990, 17819,
	20796, 23893, 27078, 30319,
	33585, 36842, 40060, 43204,
	46245, 49152, 51896, 54450,
	56789, 58888, 60729, 62291,
	63560, 64523, 65170, 65495,
	// second half mirrors the first
	65495, 65170, 64523, 63560,
	62291, 60729, 58888, 56789,
	54450, 51896, 49152, 46245,
	43204, 40060, 36842, 33585,
	30319, 27078, 23893, 20796,
	17819, 14990, 12337, 9888,
	7666, 5694, 3990, 2573,
	1456, 650, 163, 0
};

`endif

/* verilog/nlp_pkg.sv */
package nlp_pkg;

	// --------------------
	// fixed point format
	// --------------------

	// fraction bits, also the shift after every product
	localparam int Q_FRAC = 16;

	// filter and window sizes, tied to the tables below
	localparam int FIR_TAPS = 48;
	localparam int WIN_LEN = 64;

	// --------------------
	// data types
	// --------------------

	// input speech sample, 16 integer and 16 fraction bits
	typedef logic signed [31:0] sample_t;

	// wide working word, large enough for a full-scale square
	typedef logic signed [47:0] acc_t;

	// position inside the analysis window
	typedef logic [$clog2(WIN_LEN)-1:0] win_idx_t;

	// windowed output with its window position
	typedef struct packed {
		acc_t     value;
		win_idx_t index;
	} win_sample_t;

	// --------------------
	// constants
	// --------------------

	// 1.0, the bias after the notch
	localparam acc_t Q_ONE = acc_t'(1) << Q_FRAC;

	// notch pole 0.95, unsigned fraction
	localparam logic [15:0] NOTCH_POLE = 16'hF333;

	// coefficient tables
	`include "nlp_coeffs.svh"

	// --------------------
	// arithmetic
	// --------------------

	// Q16 product, full width then arithmetic shift and wrap to acc_t
	function automatic acc_t q_mult(input acc_t a, input acc_t b);
		logic signed [2*$bits(acc_t)-1:0] prod;
		prod = a * b;
		return acc_t'(prod >>> Q_FRAC);
	endfunction

endpackage

/* verilog/square_notch.sv */
`timescale 1ns/100ps

module square_notch
	import nlp_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    in_req,
	output logic    in_ack,
	input  sample_t in_sample,
	output logic    sq_req,
	input  logic    sq_ack,
	output acc_t    sq_data
);

	// pole widened to the working word
	localparam acc_t POLE = acc_t'(NOTCH_POLE);

	sample_t x_q;
	acc_t    sq_q;
	acc_t    mx;
	acc_t    my;
	acc_t    notch;
	logic    take;
	logic    busy;
	logic    x_vld;
	logic    sq_vld;
	logic    ack_wait;

	// accept only with the output side free
	assign take = in_req && !in_ack && !busy;

	// notch on the registered square
	assign notch = sq_q - mx + q_mult(POLE, my);

	// --------------------
	// control and filter state
	// --------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			in_ack <= 1'b0;
			busy <= 1'b0;
			x_vld <= 1'b0;
			sq_vld <= 1'b0;
			sq_req <= 1'b0;
			ack_wait <= 1'b0;
			mx <= '0;
			my <= '0;
		end
		else
		begin
			x_vld <= take;
			sq_vld <= x_vld;

			// input side handshake
			if (take)
			begin
				in_ack <= 1'b1;
				busy <= 1'b1;
			end
			else if (in_ack && !in_req)
				in_ack <= 1'b0;

			// output side, busy stays until ack has dropped
			if (sq_vld)
			begin
				sq_req <= 1'b1;
				mx <= sq_q;
				my <= notch;
			end
			else if (sq_req && sq_ack)
			begin
				sq_req <= 1'b0;
				ack_wait <= 1'b1;
			end
			else if (ack_wait && !sq_ack)
			begin
				ack_wait <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

	// --------------------
	// datapath
	// --------------------
	always_ff @(posedge clk)
	begin
		if (take)
			x_q <= in_sample;
		if (x_vld)
			sq_q <= q_mult(acc_t'(x_q), acc_t'(x_q));
		if (sq_vld)
			sq_data <= notch + Q_ONE;
	end

	// result must not move before the FIR has taken it
	a_sq_stable: assert property (@(posedge clk) disable iff (!rst)
		sq_req && !sq_ack |=> $stable(sq_data));

endmodule

/* verilog/fir_lowpass.sv */
`timescale 1ns/100ps

module fir_lowpass
	import nlp_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic sq_req,
	output logic sq_ack,
	input  acc_t sq_data,
	output logic fir_req,
	input  logic fir_ack,
	output acc_t fir_data
);

	localparam int TAP_W = $clog2(FIR_TAPS);
	localparam logic [TAP_W-1:0] LAST_TAP = TAP_W'(FIR_TAPS - 1);

	typedef enum logic [1:0] {
		s_idle,
		s_accum,
		s_present
	} state_t;

	state_t           state;
	acc_t             dly [FIR_TAPS];
	acc_t             acc;
	acc_t             term;
	logic [TAP_W-1:0] tap;

	// one multiply per cycle walking the taps oldest first
	assign term = q_mult(fir_coeff[tap], dly[tap]);

	// the sum is held in acc while presented
	assign fir_data = acc;

	// --------------------
	// delay line and MAC
	// --------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= s_idle;
			sq_ack <= 1'b0;
			fir_req <= 1'b0;
			tap <= '0;
			acc <= '0;
			for (int k = 0; k < FIR_TAPS; k++)
				dly[k] <= '0;
		end
		else
		begin
			// input ack follows req down
			if (sq_ack && !sq_req)
				sq_ack <= 1'b0;

			case (state)
				s_idle:
				begin
					if (sq_req && !sq_ack)
					begin
						// newest sample enters at the top
						for (int k = 0; k < FIR_TAPS - 1; k++)
							dly[k] <= dly[k + 1];
						dly[FIR_TAPS - 1] <= sq_data;
						sq_ack <= 1'b1;
						acc <= '0;
						tap <= '0;
						state <= s_accum;
					end
				end

				s_accum:
				begin
					acc <= acc + term;
					tap <= tap + 1'b1;
					if (tap == LAST_TAP)
					begin
						fir_req <= 1'b1;
						state <= s_present;
					end
				end

				s_present:
				begin
					// hold until the full four-phase exchange is over
					if (fir_req)
					begin
						if (fir_ack)
							fir_req <= 1'b0;
					end
					else if (!fir_ack)
						state <= s_idle;
				end

				default:
					state <= s_idle;
			endcase
		end
	end

	// tap index stays inside the table
	a_tap_range: assert property (@(posedge clk) disable iff (!rst)
		state == s_accum |-> tap <= LAST_TAP);

endmodule

/* verilog/decimate_window.sv */
`timescale 1ns/100ps

module decimate_window
	import nlp_pkg::*;
#(
	parameter int DEC_FACTOR = 5
)
(
	input  logic        clk,
	input  logic        rst,
	input  logic        fir_req,
	output logic        fir_ack,
	input  acc_t        fir_data,
	output logic        out_req,
	input  logic        out_ack,
	output win_sample_t out_data
);

	localparam int PH_W = (DEC_FACTOR > 1) ? $clog2(DEC_FACTOR) : 1;
	localparam logic [PH_W-1:0] LAST_PH = PH_W'(DEC_FACTOR - 1);
	localparam win_idx_t LAST_IDX = win_idx_t'(WIN_LEN - 1);

	logic [PH_W-1:0] phase;
	win_idx_t        win_idx;
	acc_t            y_q;
	logic            take;
	logic            keep;
	logic            pend;
	logic            busy;
	logic            ack_wait;

	// a pending output stalls every FIR result, kept or not
	assign take = fir_req && !fir_ack && !busy;
	assign keep = (phase == '0);

	// --------------------
	// counters and handshakes
	// --------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			fir_ack <= 1'b0;
			phase <= '0;
			win_idx <= '0;
			pend <= 1'b0;
			busy <= 1'b0;
			out_req <= 1'b0;
			ack_wait <= 1'b0;
		end
		else
		begin
			pend <= take && keep;

			if (take)
			begin
				fir_ack <= 1'b1;
				phase <= (phase == LAST_PH) ? '0 : phase + 1'b1;
				if (keep)
					busy <= 1'b1;
			end
			else if (fir_ack && !fir_req)
				fir_ack <= 1'b0;

			// window position advances once per kept output
			if (pend)
			begin
				out_req <= 1'b1;
				win_idx <= (win_idx == LAST_IDX) ? '0 : win_idx + 1'b1;
			end
			else if (out_req && out_ack)
			begin
				out_req <= 1'b0;
				ack_wait <= 1'b1;
			end
			else if (ack_wait && !out_ack)
			begin
				ack_wait <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

	// --------------------
	// window multiply
	// --------------------
	always_ff @(posedge clk)
	begin
		if (take && keep)
			y_q <= fir_data;
		if (pend)
		begin
			out_data.value <= q_mult(win_coeff[win_idx], y_q);
			out_data.index <= win_idx;
		end
	end

	a_phase_range: assert property (@(posedge clk) disable iff (!rst)
		int'(phase) < DEC_FACTOR);

endmodule

/* verilog/nlp_front_end.sv */
`timescale 1ns/100ps

module nlp_front_end
	import nlp_pkg::*;
#(
	parameter int DEC_FACTOR = 5
)
(
	input  logic        clk,
	input  logic        rst,
	input  logic        in_req,
	output logic        in_ack,
	input  sample_t     in_sample,
	output logic        out_req,
	input  logic        out_ack,
	output win_sample_t out_data
);

	// square and notch to FIR
	logic sq_req;
	logic sq_ack;
	acc_t sq_data;

	// FIR to decimator
	logic fir_req;
	logic fir_ack;
	acc_t fir_data;

	square_notch u_square_notch (
		.clk       (clk),
		.rst       (rst),
		.in_req    (in_req),
		.in_ack    (in_ack),
		.in_sample (in_sample),
		.sq_req    (sq_req),
		.sq_ack    (sq_ack),
		.sq_data   (sq_data)
	);

	fir_lowpass u_fir_lowpass (
		.clk      (clk),
		.rst      (rst),
		.sq_req   (sq_req),
		.sq_ack   (sq_ack),
		.sq_data  (sq_data),
		.fir_req  (fir_req),
		.fir_ack  (fir_ack),
		.fir_data (fir_data)
	);

	decimate_window #(
		.DEC_FACTOR (DEC_FACTOR)
	) u_decimate_window (
		.clk      (clk),
		.rst      (rst),
		.fir_req  (fir_req),
		.fir_ack  (fir_ack),
		.fir_data (fir_data),
		.out_req  (out_req),
		.out_ack  (out_ack),
		.out_data (out_data)
	);

endmodule

/* sim/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// --------------------
// checks
// --------------------

task automatic report_error(input string msg);
	$display("ERROR at %0t: %s", $time, msg);
	err_count++;
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("CHECK FAILED %s got=%h exp=%h", name, got, exp);
		err_count++;
	end
endtask

task automatic compare_value(input string name, input acc_t got, input acc_t exp);
	if (got !== exp)
	begin
		$display("CHECK FAILED %s got=%h exp=%h", name, got, exp);
		err_count++;
	end
endtask

task automatic compare_index(input string name, input win_idx_t got, input win_idx_t exp);
	if (got !== exp)
	begin
		$display("CHECK FAILED %s got=%h exp=%h", name, got, exp);
		err_count++;
	end
endtask

// takes one output with a random hold-off on out_ack under back-pressure
task automatic collect_output();
	int          stall;
	win_sample_t exp;
	col_busy = 1'b1;
	stall = bp_enable ? int'($unsigned($random(seed)) % 21) : 0;
	repeat (stall)
	begin
		@(negedge clk);
		if (!out_req)
			report_error("out_req dropped before out_ack was raised");
	end
	got_log.push_back(out_data);
	if (expected.size() == 0)
		report_error("output appeared with no expected result left");
	else
	begin
		exp = expected.pop_front();
		compare_value("out_data.value", out_data.value, exp.value);
		compare_index("out_data.index", out_data.index, exp.index);
	end
	out_ack = 1'b1;
	do
		@(negedge clk);
	while (out_req);
	out_ack = 1'b0;
	col_busy = 1'b0;
endtask

// kept count and index run 0, 1, 2 wrapping at WIN_LEN
task automatic check_sequence(input int n_in);
	int n_exp;
	n_exp = (n_in + DEC_FACTOR - 1) / DEC_FACTOR;
	if (got_log.size() != n_exp)
		report_error($sformatf("expected %0d outputs but got %0d", n_exp, got_log.size()));
	for (int i = 0; i < got_log.size(); i++)
		compare_index("out_data.index", got_log[i].index, win_idx_t'(i % WIN_LEN));
endtask

// --------------------
// stimulus
// --------------------

task automatic apply_reset();
	rst = 1'b0;
	in_req = 1'b0;
	model_reset();
	got_log.delete();
	repeat (8)
	begin
		@(negedge clk);
		compare_bit("in_ack", in_ack, 1'b0);
		compare_bit("out_req", out_req, 1'b0);
	end
	rst = 1'b1;
endtask

task automatic send_sample(input sample_t x);
	in_sample = x;
	in_req = 1'b1;
	model_step(x);
	do
		@(negedge clk);
	while (!in_ack);
	in_req = 1'b0;
	do
		@(negedge clk);
	while (in_ack);
endtask

task automatic wait_drain();
	while (expected.size() != 0 || col_busy)
		@(negedge clk);
	// a stray output during this quiet period shows up in the collector
	repeat (20) @(negedge clk);
endtask

// random speech within +-256.0
function automatic sample_t random_sample();
	logic [31:0] r;
	r = $random(seed);
	return {{7{r[24]}}, r[24:0]};
endfunction

// --------------------
// directed tests
// --------------------

task automatic test_reset();
	apply_reset();
	repeat (20)
	begin
		@(negedge clk);
		compare_bit("in_ack", in_ack, 1'b0);
		compare_bit("out_req", out_req, 1'b0);
	end
endtask

task automatic test_impulse();
	apply_reset();
	send_sample(32'h0002_0000);
	repeat (N_IMPULSE - 1) send_sample('0);
	wait_drain();
	check_sequence(N_IMPULSE);
endtask

task automatic test_random();
	apply_reset();
	stim.delete();
	repeat (N_RANDOM) stim.push_back(random_sample());
	foreach (stim[i])
		send_sample(stim[i]);
	wait_drain();
	check_sequence(N_RANDOM);
endtask

task automatic test_backpressure();
	apply_reset();
	bp_enable = 1'b1;
	foreach (stim[i])
		send_sample(stim[i]);
	wait_drain();
	bp_enable = 1'b0;
	check_sequence(N_RANDOM);
endtask

task automatic test_window_wrap();
	apply_reset();
	repeat (N_WRAP) send_sample(random_sample());
	wait_drain();
	check_sequence(N_WRAP);
endtask

`endif

/* sim/tb_nlp_front_end.sv */
`timescale 1ns/100ps

module tb_nlp_front_end
	import nlp_pkg::*;
();

	localparam int DEC_FACTOR = 5;
	localparam int N_IMPULSE = 100;
	localparam int N_RANDOM = 400;
	localparam int N_WRAP = WIN_LEN * DEC_FACTOR + 20;
	// random and back-pressure runs share one stimulus set
	localparam int TIMEOUT_CYCLES = (N_IMPULSE + 2 * N_RANDOM + N_WRAP) * 60 + 1000;

	logic        clk = 1'b0;
	logic        rst;
	logic        in_req;
	logic        in_ack;
	sample_t     in_sample;
	logic        out_req;
	logic        out_ack = 1'b0;
	win_sample_t out_data;

	integer seed;
	int     err_count;
	int     cycles = 0;
	logic   bp_enable;
	logic   col_busy = 1'b0;

	// reference model state and result logs
	acc_t        m_mx;
	acc_t        m_my;
	acc_t        m_dly [FIR_TAPS];
	int          m_fir_cnt;
	int          m_kept;
	win_sample_t expected [$];
	win_sample_t got_log [$];
	sample_t     stim [$];

	nlp_front_end #(
		.DEC_FACTOR (DEC_FACTOR)
	) DUT (
		.clk       (clk),
		.rst       (rst),
		.in_req    (in_req),
		.in_ack    (in_ack),
		.in_sample (in_sample),
		.out_req   (out_req),
		.out_ack   (out_ack),
		.out_data  (out_data)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, %0d outputs never arrived", cycles,
				expected.size());
			$display("errors: %0d", err_count + 1);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// --------------------
	// reference model
	// --------------------

	// Q16 product wrapped to the working word
	function automatic acc_t fix_mul(input acc_t a, input acc_t b);
		logic signed [95:0] wa;
		logic signed [95:0] wb;
		logic signed [95:0] p;
		wa = a;
		wb = b;
		p = wa * wb;
		return p[Q_FRAC +: 48];
	endfunction

	function automatic void model_reset();
		m_mx = '0;
		m_my = '0;
		for (int k = 0; k < FIR_TAPS; k++)
			m_dly[k] = '0;
		m_fir_cnt = 0;
		m_kept = 0;
		expected.delete();
	endfunction

	// runs one input through notch, FIR and decimator and queues any kept output
	function automatic void model_step(input sample_t x);
		acc_t        s;
		acc_t        n;
		acc_t        y;
		acc_t        pole;
		win_sample_t e;
		pole = {32'b0, NOTCH_POLE};
		s = fix_mul(acc_t'(x), acc_t'(x));
		n = s - m_mx + fix_mul(pole, m_my);
		m_mx = s;
		m_my = n;
		for (int k = 0; k < FIR_TAPS - 1; k++)
			m_dly[k] = m_dly[k + 1];
		m_dly[FIR_TAPS - 1] = n + Q_ONE;
		y = '0;
		for (int k = 0; k < FIR_TAPS; k++)
			y = y + fix_mul(fir_coeff[k], m_dly[k]);
		if (m_fir_cnt % DEC_FACTOR == 0)
		begin
			e.index = win_idx_t'(m_kept % WIN_LEN);
			e.value = fix_mul(win_coeff[m_kept % WIN_LEN], y);
			expected.push_back(e);
			m_kept++;
		end
		m_fir_cnt++;
	endfunction

	`include "tb_tasks.svh"

	// output side runs on its own
	always
	begin
		@(negedge clk);
		if (rst && out_req && !out_ack)
			collect_output();
	end

	initial
	begin
		rst = 1'b0;
		in_req = 1'b0;
		in_sample = '0;
		seed = 90540;
		err_count = 0;
		bp_enable = 1'b0;
		test_reset();
		test_impulse();
		test_random();
		test_backpressure();
		test_window_wrap();
		$display("errors: %0d", err_count);
		if (err_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* sources.f */
+incdir+verilog
+incdir+sim
verilog/nlp_pkg.sv
verilog/square_notch.sv
verilog/fir_lowpass.sv
verilog/decimate_window.sv
verilog/nlp_front_end.sv
sim/tb_nlp_front_end.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_nlp_front_end -f sources.f -o tb_nlp_front_end

out=$(./obj_dir/tb_nlp_front_end)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1
